//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN   = 32;
    localparam int INST_W = 32;

    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [2:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR, PC_HOLD} pc_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    // Size and signedness of a data access
    typedef enum logic [2:0] {MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU} mem_size_e;

endpackage

`default_nettype wire

//--- rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire rv_pkg::pc_sel_e    pc_sel_i,
    input  wire [rv_pkg::XLEN-1:0]  br_target_i,
    input  wire [rv_pkg::XLEN-1:0]  jal_target_i,
    input  wire [rv_pkg::XLEN-1:0]  jalr_target_i,
    input  wire                     br_taken_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] pc_plus4_o,
    output logic                    run_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_next;

    assign pc_plus4_o = pc_o + XLEN'(4);

    always_comb begin
        unique case (pc_sel_i)
            PC_BRANCH: pc_next = br_taken_i ? br_target_i : pc_plus4_o;
            PC_JAL:    pc_next = jal_target_i;
            PC_JALR:   pc_next = jalr_target_i;
            PC_HOLD:   pc_next = pc_o;
            default:   pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o  <= RESET_PC;
            run_o <= 1'b0;
        end else begin
            pc_o  <= pc_next;
            // First edge out of reset only arms the core
            run_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode #(
    parameter int REG_ADDR_WIDTH = 5
) (
    input  wire [rv_pkg::INST_W-1:0] inst_i,
    input  wire [rv_pkg::XLEN-1:0]   pc_i,
    input  wire rv_pkg::imm_sel_e    imm_sel_i,
    input  wire rv_pkg::op1_sel_e    op1_sel_i,
    input  wire rv_pkg::op2_sel_e    op2_sel_i,
    input  wire [rv_pkg::XLEN-1:0]   rs1_data_i,
    input  wire [rv_pkg::XLEN-1:0]   rs2_data_i,
    output logic [REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic [rv_pkg::XLEN-1:0]  op1_o,
    output logic [rv_pkg::XLEN-1:0]  op2_o,
    output logic [rv_pkg::XLEN-1:0]  br_target_o,
    output logic [rv_pkg::XLEN-1:0]  jal_target_o,
    output logic [rv_pkg::XLEN-1:0]  jalr_target_o,
    output logic                     br_eq_o,
    output logic                     br_lt_o,
    output logic                     br_ltu_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [XLEN-1:0] imm;

    // Upper bits beyond an RV32E-sized index are ignored
    assign rs1_addr_o = inst_i[15 +: REG_ADDR_WIDTH];
    assign rs2_addr_o = inst_i[20 +: REG_ADDR_WIDTH];
    assign rd_addr_o  = inst_i[7 +: REG_ADDR_WIDTH];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        unique case (imm_sel_i)
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = imm_i;
        endcase
    end

    assign op1_o = (op1_sel_i == OP1_PC) ? pc_i : rs1_data_i;
    assign op2_o = (op2_sel_i == OP2_IMM) ? imm : rs2_data_i;

    assign br_target_o   = pc_i + imm_b;
    assign jal_target_o  = pc_i + imm_j;
    assign jalr_target_o = (rs1_data_i + imm_i) & ~XLEN'(1);

    assign br_eq_o  = rs1_data_i == rs2_data_i;
    assign br_lt_o  = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign br_ltu_o = rs1_data_i < rs2_data_i;

endmodule

`default_nettype wire

//--- rv_control.sv
`timescale 1ns/10ps
`default_nettype none

module rv_control (
    input  wire [rv_pkg::INST_W-1:0] inst_i,
    input  wire                      run_i,
    input  wire                      br_eq_i,
    input  wire                      br_lt_i,
    input  wire                      br_ltu_i,
    output rv_pkg::alu_op_e          alu_op_o,
    output rv_pkg::imm_sel_e         imm_sel_o,
    output rv_pkg::op1_sel_e         op1_sel_o,
    output rv_pkg::op2_sel_e         op2_sel_o,
    output rv_pkg::pc_sel_e          pc_sel_o,
    output logic                     br_taken_o,
    output logic                     rf_we_o,
    output logic                     mem_re_o,
    output logic                     mem_we_o,
    output rv_pkg::wb_sel_e          wb_sel_o,
    output rv_pkg::mem_size_e        mem_size_o,
    output logic                     ebreak_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       rf_we, mem_re, mem_we;
    pc_sel_e    pc_sel;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // alt selects SUB and SRA
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        case (funct3)
            3'b000:  br_taken_o = br_eq_i;
            3'b001:  br_taken_o = !br_eq_i;
            3'b100:  br_taken_o = br_lt_i;
            3'b101:  br_taken_o = !br_lt_i;
            3'b110:  br_taken_o = br_ltu_i;
            3'b111:  br_taken_o = !br_ltu_i;
            default: br_taken_o = 1'b0;
        endcase
    end

    always_comb begin
        alu_op_o   = ALU_ADD;
        imm_sel_o  = IMM_I;
        op1_sel_o  = OP1_RS1;
        op2_sel_o  = OP2_RS2;
        pc_sel     = PC_PLUS4;
        wb_sel_o   = WB_ALU;
        mem_size_o = mem_size_e'(funct3);
        rf_we      = 1'b0;
        mem_re     = 1'b0;
        mem_we     = 1'b0;
        ebreak_o   = 1'b0;
        case (opcode)
            OP_LUI: begin
                alu_op_o  = ALU_PASS_B;
                imm_sel_o = IMM_U;
                op2_sel_o = OP2_IMM;
                rf_we     = 1'b1;
            end
            OP_AUIPC: begin
                imm_sel_o = IMM_U;
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM;
                rf_we     = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                pc_sel   = (opcode == OP_JAL) ? PC_JAL : PC_JALR;
                wb_sel_o = WB_PC4;
                rf_we    = 1'b1;
            end
            OP_BRANCH: begin
                imm_sel_o = IMM_B;
                pc_sel    = PC_BRANCH;
            end
            OP_LOAD: begin
                op2_sel_o = OP2_IMM;
                wb_sel_o  = WB_MEM;
                rf_we     = 1'b1;
                mem_re    = 1'b1;
                // funct3 100 and 101 are the unsigned loads
                case (funct3)
                    3'b100:  mem_size_o = MEM_BU;
                    3'b101:  mem_size_o = MEM_HU;
                    default: mem_size_o = mem_size_e'(funct3);
                endcase
            end
            OP_STORE: begin
                imm_sel_o = IMM_S;
                op2_sel_o = OP2_IMM;
                mem_we    = 1'b1;
            end
            OP_IMM: begin
                alu_op_o  = alu_from_funct(funct3, funct3 == 3'b101 && inst_i[30]);
                op2_sel_o = OP2_IMM;
                rf_we     = 1'b1;
            end
            OP_REG: begin
                alu_op_o = alu_from_funct(funct3, inst_i[30]);
                rf_we    = 1'b1;
            end
            OP_SYSTEM: begin
                if (inst_i == 32'h0010_0073) begin
                    ebreak_o = 1'b1;
                    pc_sel   = PC_HOLD;
                end
            end
            default: ;
        endcase
    end

    // Nothing retires until the run flag is up
    assign rf_we_o  = rf_we && run_i;
    assign mem_re_o = mem_re && run_i;
    assign mem_we_o = mem_we && run_i;
    assign pc_sel_o = run_i ? pc_sel : PC_HOLD;

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile #(
    parameter int ADDR_WIDTH = 5,
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   we_i,
    input  wire [ADDR_WIDTH-1:0]  waddr_i,
    input  wire [DATA_WIDTH-1:0]  wdata_i,
    input  wire [ADDR_WIDTH-1:0]  raddr1_i,
    input  wire [ADDR_WIDTH-1:0]  raddr2_i,
    output logic [DATA_WIDTH-1:0] rdata1_o,
    output logic [DATA_WIDTH-1:0] rdata2_o
);

    logic [DATA_WIDTH-1:0] regs [2**ADDR_WIDTH];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
    input  wire [rv_pkg::XLEN-1:0]  op1_i,
    input  wire [rv_pkg::XLEN-1:0]  op2_i,
    input  wire rv_pkg::alu_op_e    alu_op_i,
    input  wire rv_pkg::wb_sel_e    wb_sel_i,
    input  wire [rv_pkg::XLEN-1:0]  pc_plus4_i,
    input  wire [rv_pkg::XLEN-1:0]  load_data_i,
    output logic [rv_pkg::XLEN-1:0] alu_result_o,
    output logic [rv_pkg::XLEN-1:0] wb_data_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = op2_i[4:0];

    always_comb begin
        unique case (alu_op_i)
            ALU_SUB:    alu_result_o = op1_i - op2_i;
            ALU_AND:    alu_result_o = op1_i & op2_i;
            ALU_OR:     alu_result_o = op1_i | op2_i;
            ALU_XOR:    alu_result_o = op1_i ^ op2_i;
            ALU_SLL:    alu_result_o = op1_i << shamt;
            ALU_SRL:    alu_result_o = op1_i >> shamt;
            ALU_SRA:    alu_result_o = $signed(op1_i) >>> shamt;
            ALU_SLT:    alu_result_o = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU:   alu_result_o = {{(XLEN-1){1'b0}}, op1_i < op2_i};
            ALU_PASS_B: alu_result_o = op2_i;
            default:    alu_result_o = op1_i + op2_i;
        endcase
    end

    // Write-back source
    always_comb begin
        unique case (wb_sel_i)
            WB_MEM:  wb_data_o = load_data_i;
            WB_PC4:  wb_data_o = pc_plus4_i;
            default: wb_data_o = alu_result_o;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
    input  wire [1:0]               addr_i,
    input  wire [rv_pkg::XLEN-1:0]  store_data_i,
    input  wire rv_pkg::mem_size_e  mem_size_i,
    input  wire [rv_pkg::XLEN-1:0]  mem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] wdata_o,
    output logic [3:0]              wmask_o,
    output logic [rv_pkg::XLEN-1:0] load_data_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] rdata_shifted;

    // Move store data into the addressed byte lanes
    assign wdata_o = store_data_i << {addr_i, 3'b000};

    always_comb begin
        unique case (mem_size_i)
            MEM_B, MEM_BU: wmask_o = 4'b0001 << addr_i;
            MEM_H, MEM_HU: wmask_o = 4'b0011 << addr_i;
            default:       wmask_o = 4'b1111;
        endcase
    end

    assign rdata_shifted = mem_rdata_i >> {addr_i, 3'b000};

    always_comb begin
        unique case (mem_size_i)
            MEM_B:   load_data_o = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            MEM_BU:  load_data_o = {24'b0, rdata_shifted[7:0]};
            MEM_H:   load_data_o = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            MEM_HU:  load_data_o = {16'b0, rdata_shifted[15:0]};
            default: load_data_o = mem_rdata_i;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
    parameter int                      REG_ADDR_WIDTH = 5,
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC       = 32'h8000_0000
) (
    input  wire                       clk,
    input  wire                       rst_n_i,
    output logic [rv_pkg::XLEN-1:0]   imem_addr_o,
    input  wire [rv_pkg::INST_W-1:0]  imem_rdata_i,
    output logic [rv_pkg::XLEN-1:0]   dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0]   dmem_wdata_o,
    output logic [3:0]                dmem_wmask_o,
    output logic                      dmem_we_o,
    output logic                      dmem_re_o,
    input  wire [rv_pkg::XLEN-1:0]    dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0]   pc_o,
    output logic                      rf_we_o,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic [rv_pkg::XLEN-1:0]   rd_data_o,
    output logic                      ebreak_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_plus4, br_target, jal_target, jalr_target;
    logic [XLEN-1:0] op1, op2, rs1_data, rs2_data, load_data;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr;
    logic            run, br_taken, br_eq, br_lt, br_ltu;
    alu_op_e         alu_op;
    imm_sel_e        imm_sel;
    op1_sel_e        op1_sel;
    op2_sel_e        op2_sel;
    pc_sel_e         pc_sel;
    wb_sel_e         wb_sel;
    mem_size_e       mem_size;

    assign imem_addr_o = pc_o;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_n_i(rst_n_i), .pc_sel_i(pc_sel),
        .br_target_i(br_target), .jal_target_i(jal_target), .jalr_target_i(jalr_target),
        .br_taken_i(br_taken), .pc_o(pc_o), .pc_plus4_o(pc_plus4), .run_o(run)
    );

    rv_decode #(.REG_ADDR_WIDTH(REG_ADDR_WIDTH)) u_decode (
        .inst_i(imem_rdata_i), .pc_i(pc_o), .imm_sel_i(imm_sel),
        .op1_sel_i(op1_sel), .op2_sel_i(op2_sel),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr_o),
        .op1_o(op1), .op2_o(op2), .br_target_o(br_target), .jal_target_o(jal_target),
        .jalr_target_o(jalr_target), .br_eq_o(br_eq), .br_lt_o(br_lt), .br_ltu_o(br_ltu)
    );

    rv_control u_control (
        .inst_i(imem_rdata_i), .run_i(run),
        .br_eq_i(br_eq), .br_lt_i(br_lt), .br_ltu_i(br_ltu),
        .alu_op_o(alu_op), .imm_sel_o(imm_sel), .op1_sel_o(op1_sel), .op2_sel_o(op2_sel),
        .pc_sel_o(pc_sel), .br_taken_o(br_taken), .rf_we_o(rf_we_o),
        .mem_re_o(dmem_re_o), .mem_we_o(dmem_we_o), .wb_sel_o(wb_sel),
        .mem_size_o(mem_size), .ebreak_o(ebreak_o)
    );

    rv_regfile #(.ADDR_WIDTH(REG_ADDR_WIDTH), .DATA_WIDTH(XLEN)) u_regfile (
        .clk(clk), .rst_n_i(rst_n_i), .we_i(rf_we_o), .waddr_i(rd_addr_o),
        .wdata_i(rd_data_o), .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    // ALU result doubles as the data address
    rv_execute u_execute (
        .op1_i(op1), .op2_i(op2), .alu_op_i(alu_op), .wb_sel_i(wb_sel),
        .pc_plus4_i(pc_plus4), .load_data_i(load_data),
        .alu_result_o(dmem_addr_o), .wb_data_o(rd_data_o)
    );

    rv_lsu u_lsu (
        .addr_i(dmem_addr_o[1:0]), .store_data_i(rs2_data), .mem_size_i(mem_size),
        .mem_rdata_i(dmem_rdata_i), .wdata_o(dmem_wdata_o), .wmask_o(dmem_wmask_o),
        .load_data_o(load_data)
    );

endmodule

`default_nettype wire

//--- rv_core_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_checker #(
    parameter int REG_ADDR_WIDTH = 5
) (
    input wire                      clk,
    input wire                      rst_n_i,
    input wire                      rf_we_i,
    input wire                      dmem_we_i,
    input wire                      dmem_re_i,
    input wire                      ebreak_i,
    input wire [rv_pkg::XLEN-1:0]   pc_i,
    input wire [3:0]                dmem_wmask_i,
    input wire [REG_ADDR_WIDTH-1:0] rd_addr_i,
    input wire [rv_pkg::XLEN-1:0]   x0_value_i
);

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> !(rf_we_i || dmem_we_i || dmem_re_i))
        else $error("enable active during reset");

    a_halt_holds_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        ebreak_i |=> $stable(pc_i))
        else $error("pc moved after ebreak");

    a_store_mask: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_we_i |-> dmem_wmask_i != 4'b0000)
        else $error("store with empty byte mask");

    // x0 stays zero across a write aimed at it
    a_x0_fixed: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rf_we_i && rd_addr_i == '0) |=> x0_value_i == '0)
        else $error("register 0 changed");

endmodule

bind rv_core rv_core_checker #(.REG_ADDR_WIDTH(REG_ADDR_WIDTH)) u_checker (
    .clk(clk), .rst_n_i(rst_n_i), .rf_we_i(rf_we_o), .dmem_we_i(dmem_we_o),
    .dmem_re_i(dmem_re_o), .ebreak_i(ebreak_o), .pc_i(pc_o), .dmem_wmask_i(dmem_wmask_o),
    .rd_addr_i(rd_addr_o), .x0_value_i(u_regfile.regs[0])
);

`default_nettype wire

//--- rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam int              RAW       = 5;
    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam int              PROG_LEN  = 64;
    localparam int              DWORDS    = 64;
    localparam logic [11:0]     DATA_BASE = 12'h400;
    localparam int              MAX_CYC   = 400;
    localparam int              HALT_WIN  = 20;

    logic              clk, rst_n_i;
    logic [XLEN-1:0]   imem_addr_o, dmem_addr_o, dmem_wdata_o, dmem_rdata_i, pc_o, rd_data_o;
    logic [INST_W-1:0] imem_rdata_i;
    logic [3:0]        dmem_wmask_o;
    logic              dmem_we_o, dmem_re_o, rf_we_o, ebreak_o;
    logic [RAW-1:0]    rd_addr_o;

    logic [INST_W-1:0] imem [PROG_LEN];
    logic [XLEN-1:0]   dmem [DWORDS];
    logic [XLEN-1:0]   m_dmem [DWORDS];
    logic [XLEN-1:0]   m_regs [32];
    logic [XLEN-1:0]   m_pc;
    int                mismatches, failures, retired;

    rv_core #(.REG_ADDR_WIDTH(RAW), .RESET_PC(RESET_PC)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Combinational memories with data writes committed at the edge
    assign imem_rdata_i = imem[imem_addr_o[7:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_we_o && dmem_wmask_o[b])
                dmem[dmem_addr_o[7:2]][8*b +: 8] <= dmem_wdata_o[8*b +: 8];
        end
    end

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Aligned data offset for access size f3[1:0]
    function automatic logic [11:0] data_offset(logic [1:0] size);
        logic [11:0] off;
        off = DATA_BASE + 12'(($urandom % DWORDS) * 4);
        if (size == 2'd0)
            off = off + 12'($urandom % 4);
        else if (size == 2'd1)
            off = off + 12'(2 * ($urandom % 2));
        return off;
    endfunction

    task automatic build_program();
        int          k;
        int          steps;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [2:0]  br_f3 [6];
        logic [2:0]  ld_f3 [5];
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        k = 0;
        // Seed x1..x7 with random values
        for (int r = 1; r < 8; r++) begin
            imem[k] = {20'($urandom), 5'(r), OP_LUI};
            imem[k+1] = enc_i(12'($urandom), 5'(r), 3'd0, 5'(r), OP_IMM);
            k = k + 2;
        end
        while (k < PROG_LEN - 1) begin
            rd  = 5'($urandom % 8);
            rs1 = 5'($urandom % 8);
            rs2 = 5'($urandom % 8);
            f3  = 3'($urandom);
            steps = 1 + int'($urandom % 4);
            if (k + steps > PROG_LEN - 1)
                steps = PROG_LEN - 1 - k;
            case ($urandom % 8)
                0: imem[k] = {((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00,
                              rs2, rs1, f3, rd, OP_REG};
                1: begin
                    imm = 12'($urandom);
                    if (f3 == 3'd1)
                        imm = {7'h00, imm[4:0]};
                    else if (f3 == 3'd5)
                        imm = {($urandom % 2 == 1) ? 7'h20 : 7'h00, imm[4:0]};
                    imem[k] = enc_i(imm, rs1, f3, rd, OP_IMM);
                end
                2: imem[k] = {20'($urandom), rd, ($urandom % 2 == 1) ? OP_LUI : OP_AUIPC};
                3: begin
                    f3 = 3'($urandom % 3);
                    imm = data_offset(f3[1:0]);
                    imem[k] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], OP_STORE};
                end
                4: begin
                    f3 = ld_f3[$urandom % 5];
                    imem[k] = enc_i(data_offset(f3[1:0]), 5'd0, f3, rd, OP_LOAD);
                end
                5: imem[k] = enc_b(13'(steps * 4), rs2, rs1, br_f3[$urandom % 6]);
                6: imem[k] = enc_j(21'(steps * 4), rd);
                default: imem[k] = enc_i(12'(RESET_PC) + 12'((k + steps) * 4), 5'd0, 3'd0,
                                         rd, OP_JALR);
            endcase
            k++;
        end
        imem[PROG_LEN-1] = 32'h0010_0073;
    endtask

    function automatic logic [31:0] model_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction of the ISA model and reports its effects
    task automatic model_step(output logic e_we, output logic [4:0] e_rd,
                              output logic [31:0] e_wd, output logic e_st,
                              output logic [31:0] e_sa, output logic [31:0] e_sd,
                              output logic [3:0] e_sm, output logic e_ld,
                              output logic e_halt);
        logic [31:0] inst, a, b, immi, imms, immb, immj, nxt, word;
        logic [2:0]  f3;
        logic        taken;
        inst = imem[m_pc[7:2]];
        f3   = inst[14:12];
        a    = m_regs[inst[19:15]];
        b    = m_regs[inst[24:20]];
        immi = {{20{inst[31]}}, inst[31:20]};
        imms = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immb = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        immj = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        e_we = 1'b0;
        e_rd = inst[11:7];
        e_wd = '0;
        e_st = 1'b0;
        e_sa = '0;
        e_sd = '0;
        e_sm = '0;
        e_ld = 1'b0;
        e_halt = 1'b0;
        nxt = m_pc + 32'd4;
        case (inst[6:0])
            OP_LUI: begin
                e_we = 1'b1;
                e_wd = {inst[31:12], 12'd0};
            end
            OP_AUIPC: begin
                e_we = 1'b1;
                e_wd = m_pc + {inst[31:12], 12'd0};
            end
            OP_JAL, OP_JALR: begin
                e_we = 1'b1;
                e_wd = m_pc + 32'd4;
                nxt = (inst[6:0] == OP_JAL) ? m_pc + immj : (a + immi) & ~32'd1;
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0:    taken = a == b;
                    3'd1:    taken = a != b;
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken)
                    nxt = m_pc + immb;
            end
            OP_LOAD: begin
                e_ld = 1'b1;
                e_sa = a + immi;
                word = m_dmem[e_sa[7:2]] >> (8 * e_sa[1:0]);
                e_we = 1'b1;
                case (f3)
                    3'd0:    e_wd = {{24{word[7]}}, word[7:0]};
                    3'd1:    e_wd = {{16{word[15]}}, word[15:0]};
                    3'd4:    e_wd = {24'd0, word[7:0]};
                    3'd5:    e_wd = {16'd0, word[15:0]};
                    default: e_wd = m_dmem[e_sa[7:2]];
                endcase
            end
            OP_STORE: begin
                e_st = 1'b1;
                e_sa = a + imms;
                e_sd = b << (8 * e_sa[1:0]);
                e_sm = (f3 == 3'd0) ? 4'b0001 << e_sa[1:0] :
                       (f3 == 3'd1) ? 4'b0011 << e_sa[1:0] : 4'b1111;
                for (int i = 0; i < 4; i++) begin
                    if (e_sm[i])
                        m_dmem[e_sa[7:2]][8*i +: 8] = e_sd[8*i +: 8];
                end
            end
            OP_IMM: begin
                e_we = 1'b1;
                e_wd = model_alu(f3, f3 == 3'd5 && inst[30], a, immi);
            end
            OP_REG: begin
                e_we = 1'b1;
                e_wd = model_alu(f3, inst[30], a, b);
            end
            default: begin
                e_halt = 1'b1;
                nxt = m_pc;
            end
        endcase
        if (e_we && e_rd != 5'd0)
            m_regs[e_rd] = e_wd;
        m_pc = nxt;
    endtask

    task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: pc_o %h, expected %h", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_writeback(input logic got_we, input logic [RAW-1:0] got_rd,
                                   input logic [XLEN-1:0] got_data, input logic exp_we,
                                   input logic [RAW-1:0] exp_rd, input logic [XLEN-1:0] exp_data);
        if (got_we !== exp_we || (exp_we && (got_rd !== exp_rd || got_data !== exp_data))) begin
            $display("mismatch at %0t: write-back we=%b x%0d=%h, expected we=%b x%0d=%h",
                     $time, got_we, got_rd, got_data, exp_we, exp_rd, exp_data);
            mismatches++;
        end
    endtask

    task automatic check_store(input logic got_we, input logic [XLEN-1:0] got_addr,
                               input logic [XLEN-1:0] got_data, input logic [3:0] got_mask,
                               input logic exp_we, input logic [XLEN-1:0] exp_addr,
                               input logic [XLEN-1:0] exp_data, input logic [3:0] exp_mask);
        logic [XLEN-1:0] lanes;
        // Only enabled byte lanes carry defined data
        for (int i = 0; i < 4; i++)
            lanes[8*i +: 8] = {8{exp_mask[i]}};
        if (got_we !== exp_we || (exp_we && (got_addr !== exp_addr || got_mask !== exp_mask ||
                                             (got_data & lanes) !== (exp_data & lanes)))) begin
            $display("mismatch at %0t: store we=%b [%h]=%h mask %b, expected we=%b [%h]=%h mask %b",
                     $time, got_we, got_addr, got_data, got_mask,
                     exp_we, exp_addr, exp_data, exp_mask);
            mismatches++;
        end
    endtask

    task automatic check_read(input logic got_re, input logic exp_re);
        if (got_re !== exp_re) begin
            $display("mismatch at %0t: dmem_re_o %b, expected %b", $time, got_re, exp_re);
            mismatches++;
        end
    endtask

    task automatic check_halt(input logic got_halt, input logic exp_halt);
        if (got_halt !== exp_halt) begin
            $display("mismatch at %0t: ebreak_o %b, expected %b", $time, got_halt, exp_halt);
            mismatches++;
        end
    endtask

    task automatic check_quiet_reset();
        check_pc(pc_o, RESET_PC);
        if (rf_we_o || dmem_we_o || dmem_re_o) begin
            $display("Enable active at %0t while the core is held in reset", $time);
            failures++;
        end
    endtask

    initial begin
        logic            e_we, e_st, e_ld, e_halt, halted;
        logic [4:0]      e_rd;
        logic [3:0]      e_sm;
        logic [XLEN-1:0] e_wd, e_sa, e_sd;
        int              cycles;
        rst_n_i = 1'b0;
        mismatches = 0;
        failures = 0;
        retired = 0;
        void'($urandom(32'h56ee));
        build_program();
        for (int i = 0; i < DWORDS; i++) begin
            dmem[i] = (32'h400 + 32'(i * 4)) * 32'h9E37_79B1;
            m_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        m_pc = RESET_PC;
        repeat (16) begin
            @(posedge clk);
            #1 check_quiet_reset();
        end
        rst_n_i = 1'b1;
        #1 check_quiet_reset();
        halted = 1'b0;
        cycles = 0;
        while (!halted && cycles < MAX_CYC) begin
            @(posedge clk);
            #1 cycles++;
            check_pc(pc_o, m_pc);
            model_step(e_we, e_rd, e_wd, e_st, e_sa, e_sd, e_sm, e_ld, e_halt);
            check_writeback(rf_we_o, rd_addr_o, rd_data_o, e_we, e_rd, e_wd);
            check_store(dmem_we_o, dmem_addr_o, dmem_wdata_o, dmem_wmask_o, e_st, e_sa, e_sd, e_sm);
            check_read(dmem_re_o, e_ld);
            check_halt(ebreak_o, e_halt);
            if (e_halt)
                halted = 1'b1;
            else
                retired++;
        end
        if (!halted) begin
            $display("Timeout: the core did not reach EBREAK within %0d cycles", MAX_CYC);
            failures++;
        end else begin
            repeat (HALT_WIN) begin
                @(posedge clk);
                #1 check_pc(pc_o, m_pc);
                if (!ebreak_o || rf_we_o || dmem_we_o) begin
                    $display("Core left the halt state or wrote at %0t", $time);
                    failures++;
                end
            end
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d instructions retired",
                 mismatches, failures, retired);
        if (mismatches == 0 && failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_control.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
rv_core_checker.sv
rv_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module rv_core_tb -Mdir obj_dir -o vsim
	./obj_dir/vsim > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
